//--- grid_display_consts.svh
`ifndef GRID_DISPLAY_CONSTS_SVH
`define GRID_DISPLAY_CONSTS_SVH

////////////////////////////////////////
// 640x480 at 60 Hz, 25 MHz pixel clock
////////////////////////////////////////

// horizontal, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

////////////////////////////////////////
// play field
////////////////////////////////////////

// 32 pixel cells
`define CELL_SHIFT 5
`define GRID_COLS 18
`define GRID_ROWS 13
`define GRID_CELLS (`GRID_COLS * `GRID_ROWS)

// border lines sit on these coordinates
`define FIELD_LO 32
`define FIELD_X_HI 608
`define FIELD_Y_HI 448

// palette
`define COLOR_BORDER 24'hF0F078
`define COLOR_GRIDLINE 24'h502850
`define COLOR_CELL 24'h28B450

// queue depths, also the initial credit counts
`define CMD_DEPTH 4
`define RSP_DEPTH 4

`endif

//--- grid_display_pkg.sv
package grid_display_pkg;

	////////////////////////////////////////
	// host side payloads
	////////////////////////////////////////

	// one queued host command
	typedef struct packed {
		logic       wr;
		logic [7:0] addr;
		logic       data;
	} cell_cmd_t;

	// read result, tagged with its cell address
	typedef struct packed {
		logic [7:0] addr;
		logic       data;
	} cell_rsp_t;

	////////////////////////////////////////
	// video payload
	////////////////////////////////////////

	// 8 bits per channel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

//--- credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
)
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t pop_data_o,
	output logic     empty_o,
	output logic     full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// wrap at DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// storage
	always_ff @(posedge clk)
	begin
		if (push_i)
			mem[wr_ptr] <= push_data_i;
	end

	// pointers and occupancy
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop_i)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// show-ahead, head is valid whenever not empty
	assign pop_data_o = mem[rd_ptr];
	assign empty_o    = (count == '0);
	assign full_o     = (count == CNT_W'(DEPTH));

	// sender spent a credit it never got back
	a_credit_overrun: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(push_i && full_o))
		else $error("credit_fifo: push while full");

	a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(pop_i && empty_o))
		else $error("credit_fifo: pop while empty");

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

`include "grid_display_consts.svh"

module vga_timing
(
	input  logic        clk,
	input  logic        rst_n_i,
	output logic        hsync_o,
	output logic        vsync_o,
	output logic        de_o,
	output logic [10:0] pix_x_o,
	output logic [10:0] pix_y_o
);

	logic [10:0] h_cnt;
	logic [10:0] v_cnt;
	logic        h_last;

	assign h_last = (h_cnt == 11'(`H_TOTAL - 1));

	////////////////////////////////////////
	// frame counters
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			h_cnt <= h_last ? '0 : h_cnt + 1'b1;
			// line advances on the last pixel clock of the line
			if (h_last)
				v_cnt <= (v_cnt == 11'(`V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// registered decode
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
			de_o    <= 1'b0;
			pix_x_o <= '0;
			pix_y_o <= '0;
		end
		else
		begin
			// active low pulses after the front porch
			hsync_o <= !((h_cnt >= `H_ACTIVE + `H_FRONT) &&
				(h_cnt < `H_ACTIVE + `H_FRONT + `H_SYNC));
			vsync_o <= !((v_cnt >= `V_ACTIVE + `V_FRONT) &&
				(v_cnt < `V_ACTIVE + `V_FRONT + `V_SYNC));
			de_o    <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
			pix_x_o <= h_cnt;
			pix_y_o <= v_cnt;
		end
	end

	// blanking must cover both sync pulses
	a_de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n_i)
		de_o |-> (hsync_o && vsync_o))
		else $error("vga_timing: de_o high during sync");

endmodule

//--- grid_vram.sv
`timescale 1ns/1ps

`include "grid_display_consts.svh"

module grid_vram
(
	input  logic                  clk,
	input  logic                  rst_n_i,
	// host port
	input  logic                  ram_wen_i,
	input  logic                  ram_ren_i,
	input  logic [7:0]            ram_addr_i,
	input  logic                  ram_wdata_i,
	output logic                  ram_rdata_o,
	// scan input from the timing generator
	input  logic                  hs_i,
	input  logic                  vs_i,
	input  logic                  de_i,
	input  logic [10:0]           pix_x_i,
	input  logic [10:0]           pix_y_i,
	// video out
	output logic                  hs_o,
	output logic                  vs_o,
	output logic                  de_o,
	output grid_display_pkg::rgb_t rgb_o
);

	logic              mem [`GRID_CELLS];
	logic [4:0]        cell_x;
	logic [4:0]        cell_y;
	logic [7:0]        scan_addr;
	logic              cell_on;
	logic [2:0]        hs_d;
	logic [2:0]        vs_d;
	logic [2:0]        de_d;
	logic [2:0][10:0]  x_d;
	logic [2:0][10:0]  y_d;
	logic              outside;
	logic              on_edge;
	logic              on_grid;

	// host side, out of range writes fall away
	always_ff @(posedge clk)
	begin
		if (ram_wen_i && (ram_addr_i < `GRID_CELLS))
			mem[ram_addr_i] <= ram_wdata_i;
		if (ram_ren_i)
			ram_rdata_o <= (ram_addr_i < `GRID_CELLS) ? mem[ram_addr_i] : 1'b0;
	end

	////////////////////////////////////////
	// scan pipeline, stages 1 to 3
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// s1 cell column and row, field starts one cell in
		cell_x    <= 5'(pix_x_i >> `CELL_SHIFT) - 5'd1;
		cell_y    <= 5'(pix_y_i >> `CELL_SHIFT) - 5'd1;
		// s2 linear address, row major
		scan_addr <= 8'(cell_y * `GRID_COLS + cell_x);
		// s3 cell lookup
		cell_on   <= (scan_addr < `GRID_CELLS) ? mem[scan_addr] : 1'b0;
		x_d       <= {x_d[1:0], pix_x_i};
		y_d       <= {y_d[1:0], pix_y_i};
	end

	// control travels alongside
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hs_d <= '1;
			vs_d <= '1;
			de_d <= '0;
		end
		else
		begin
			hs_d <= {hs_d[1:0], hs_i};
			vs_d <= {vs_d[1:0], vs_i};
			de_d <= {de_d[1:0], de_i};
		end
	end

	// field classification of the stage 3 pixel
	assign outside = (x_d[2] < `FIELD_LO) || (x_d[2] > `FIELD_X_HI) ||
		(y_d[2] < `FIELD_LO) || (y_d[2] > `FIELD_Y_HI);
	assign on_edge = (x_d[2] == `FIELD_LO) || (x_d[2] == `FIELD_X_HI) ||
		(y_d[2] == `FIELD_LO) || (y_d[2] == `FIELD_Y_HI);
	assign on_grid = (x_d[2][`CELL_SHIFT-1:0] == '0) || (y_d[2][`CELL_SHIFT-1:0] == '0);

	////////////////////////////////////////
	// stage 4, colour and sync out
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hs_o  <= 1'b1;
			vs_o  <= 1'b1;
			de_o  <= 1'b0;
			rgb_o <= '0;
		end
		else
		begin
			hs_o <= hs_d[2];
			vs_o <= vs_d[2];
			de_o <= de_d[2];
			// priority, first match wins
			if (!de_d[2] || outside)
				rgb_o <= '0;
			else if (on_edge)
				rgb_o <= `COLOR_BORDER;
			else if (on_grid)
				rgb_o <= `COLOR_GRIDLINE;
			else if (cell_on)
				rgb_o <= `COLOR_CELL;
			else
				rgb_o <= '0;
		end
	end

	// divide and multiply stages must land on a real cell inside the border
	a_scan_addr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		(de_d[1] && (x_d[1] > `FIELD_LO) && (x_d[1] < `FIELD_X_HI) &&
		(y_d[1] > `FIELD_LO) && (y_d[1] < `FIELD_Y_HI)) |-> (scan_addr < `GRID_CELLS))
		else $error("grid_vram: scan address %0d out of range", scan_addr);

endmodule

//--- grid_cmd_port.sv
`timescale 1ns/1ps

`include "grid_display_consts.svh"

module grid_cmd_port
(
	input  logic       clk,
	input  logic       rst_n_i,
	// host commands
	input  logic       cmd_valid_i,
	input  logic       cmd_write_i,
	input  logic [7:0] cmd_addr_i,
	input  logic       cmd_data_i,
	output logic       cmd_credit_o,
	// host responses
	output logic       rsp_valid_o,
	output logic [7:0] rsp_addr_o,
	output logic       rsp_data_o,
	input  logic       rsp_credit_i,
	// memory host port
	output logic       ram_wen_o,
	output logic       ram_ren_o,
	output logic [7:0] ram_addr_o,
	output logic       ram_wdata_o,
	input  logic       ram_rdata_i
);

	localparam int CNT_W = $clog2(`RSP_DEPTH + 1);

	grid_display_pkg::cell_cmd_t cmd_in;
	grid_display_pkg::cell_cmd_t cmd_head;
	grid_display_pkg::cell_rsp_t rsp_in;
	grid_display_pkg::cell_rsp_t rsp_head;
	logic             cmd_empty;
	logic             cmd_pop;
	logic             rd_issue;
	logic             rd_wait;
	logic [7:0]       rd_addr_q;
	logic             rsp_empty;
	logic             rsp_full;
	logic             rsp_send;
	logic [CNT_W-1:0] slots_free;
	logic [CNT_W-1:0] host_credits;

	assign cmd_in = '{wr: cmd_write_i, addr: cmd_addr_i, data: cmd_data_i};

	credit_fifo #(
		.payload_t (grid_display_pkg::cell_cmd_t),
		.DEPTH     (`CMD_DEPTH)
	) cmd_q (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (cmd_valid_i),
		.push_data_i (cmd_in),
		.pop_i       (cmd_pop),
		.pop_data_o  (cmd_head),
		.empty_o     (cmd_empty),
		.full_o      ()
	);

	////////////////////////////////////////
	// command issue
	////////////////////////////////////////

	// writes go straight out, reads wait for a free response slot
	assign cmd_pop  = !cmd_empty && (cmd_head.wr || (slots_free != '0));
	assign rd_issue = cmd_pop && !cmd_head.wr;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ram_wen_o    <= 1'b0;
			ram_ren_o    <= 1'b0;
			rd_wait      <= 1'b0;
			cmd_credit_o <= 1'b0;
		end
		else
		begin
			ram_wen_o    <= cmd_pop && cmd_head.wr;
			ram_ren_o    <= rd_issue;
			// read data shows up the cycle after ram_ren_o
			rd_wait      <= ram_ren_o;
			cmd_credit_o <= cmd_pop;
		end
	end

	always_ff @(posedge clk)
	begin
		ram_addr_o  <= cmd_head.addr;
		ram_wdata_o <= cmd_head.data;
		rd_addr_q   <= ram_addr_o;
	end

	////////////////////////////////////////
	// response queue and host credits
	////////////////////////////////////////

	assign rsp_in = '{addr: rd_addr_q, data: ram_rdata_i};

	credit_fifo #(
		.payload_t (grid_display_pkg::cell_rsp_t),
		.DEPTH     (`RSP_DEPTH)
	) rsp_q (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (rd_wait),
		.push_data_i (rsp_in),
		.pop_i       (rsp_send),
		.pop_data_o  (rsp_head),
		.empty_o     (rsp_empty),
		.full_o      (rsp_full)
	);

	// present only while the host has room
	assign rsp_send    = !rsp_empty && (host_credits != '0);
	assign rsp_valid_o = rsp_send;
	assign rsp_addr_o  = rsp_head.addr;
	assign rsp_data_o  = rsp_head.data;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			slots_free   <= CNT_W'(`RSP_DEPTH);
			host_credits <= CNT_W'(`RSP_DEPTH);
		end
		else
		begin
			// slot held from read issue until the response leaves
			case ({rd_issue, rsp_send})
				2'b10:   slots_free <= slots_free - 1'b1;
				2'b01:   slots_free <= slots_free + 1'b1;
				default: slots_free <= slots_free;
			endcase
			case ({rsp_send, rsp_credit_i})
				2'b10:   host_credits <= host_credits - 1'b1;
				2'b01:   host_credits <= host_credits + 1'b1;
				default: host_credits <= host_credits;
			endcase
		end
	end

	// host never returns more than it was given
	a_host_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
		host_credits <= CNT_W'(`RSP_DEPTH))
		else $error("grid_cmd_port: host credits %0d above limit", host_credits);

	// a reserved slot always exists for the pushed read
	a_rsp_slot: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_wait |-> !rsp_full || rsp_send)
		else $error("grid_cmd_port: response with no reserved slot");

endmodule

//--- grid_display_top.sv
`timescale 1ns/1ps

module grid_display_top
(
	input  logic                   clk,
	input  logic                   rst_n_i,
	// host command channel
	input  logic                   cmd_valid_i,
	input  logic                   cmd_write_i,
	input  logic [7:0]             cmd_addr_i,
	input  logic                   cmd_data_i,
	output logic                   cmd_credit_o,
	// host response channel
	output logic                   rsp_valid_o,
	output logic [7:0]             rsp_addr_o,
	output logic                   rsp_data_o,
	input  logic                   rsp_credit_i,
	// video
	output logic                   hs_o,
	output logic                   vs_o,
	output logic                   de_o,
	output grid_display_pkg::rgb_t rgb_o
);

	// timing generator to renderer
	logic        hsync;
	logic        vsync;
	logic        de;
	logic [10:0] pix_x;
	logic [10:0] pix_y;

	// command port to cell memory
	logic        ram_wen;
	logic        ram_ren;
	logic [7:0]  ram_addr;
	logic        ram_wdata;
	logic        ram_rdata;

	vga_timing u_timing (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.hsync_o (hsync),
		.vsync_o (vsync),
		.de_o    (de),
		.pix_x_o (pix_x),
		.pix_y_o (pix_y)
	);

	grid_cmd_port u_cmd_port (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_write_i  (cmd_write_i),
		.cmd_addr_i   (cmd_addr_i),
		.cmd_data_i   (cmd_data_i),
		.cmd_credit_o (cmd_credit_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_addr_o   (rsp_addr_o),
		.rsp_data_o   (rsp_data_o),
		.rsp_credit_i (rsp_credit_i),
		.ram_wen_o    (ram_wen),
		.ram_ren_o    (ram_ren),
		.ram_addr_o   (ram_addr),
		.ram_wdata_o  (ram_wdata),
		.ram_rdata_i  (ram_rdata)
	);

	// renderer, four stages behind the timing generator
	grid_vram u_vram (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ram_wen_i   (ram_wen),
		.ram_ren_i   (ram_ren),
		.ram_addr_i  (ram_addr),
		.ram_wdata_i (ram_wdata),
		.ram_rdata_o (ram_rdata),
		.hs_i        (hsync),
		.vs_i        (vsync),
		.de_i        (de),
		.pix_x_i     (pix_x),
		.pix_y_i     (pix_y),
		.hs_o        (hs_o),
		.vs_o        (vs_o),
		.de_o        (de_o),
		.rgb_o       (rgb_o)
	);

endmodule

//--- tb_grid_display.sv
`timescale 1ns/1ps

`include "grid_display_consts.svh"

module tb_grid_display;

	// three frames plus margin covers setup, the sync frame and the checked frame
	localparam int TIMEOUT_CYCLES = 3 * `H_TOTAL * `V_TOTAL + 2000;

	logic                   clk;
	logic                   rst_n_i;
	logic                   cmd_valid_i;
	logic                   cmd_write_i;
	logic [7:0]             cmd_addr_i;
	logic                   cmd_data_i;
	logic                   cmd_credit_o;
	logic                   rsp_valid_o;
	logic [7:0]             rsp_addr_o;
	logic                   rsp_data_o;
	logic                   rsp_credit_i;
	logic                   hs_o;
	logic                   vs_o;
	logic                   de_o;
	grid_display_pkg::rgb_t rgb_o;

	// host model state
	int   seed;
	int   errors;
	int   cycle_cnt;
	int   cmd_credits;
	int   cmd_sent_cnt;
	int   cmd_credit_cnt;
	int   rd_sent_cnt;
	int   rsp_recv_cnt;
	int   credit_ret_cnt;
	int   pix_checked;
	int   gap_tbl [64];
	logic ref_cells [256];
	logic [7:0] exp_addr_tbl [256];
	logic exp_data_tbl [256];
	logic [7:0] exp_rsp_addr;
	logic exp_rsp_data;
	logic withhold;
	logic render_en;

	// pixel tracker state
	logic hs_prev;
	logic vs_prev;
	logic hs_fall;
	logic hs_rise;
	logic vs_fall;
	logic vs_rise;
	logic line_had_de;
	logic hs_seen;
	int   px;
	int   py;
	int   hs_low_len;
	int   vs_low_len;
	int   hs_period;
	grid_display_pkg::rgb_t exp_colour;

	grid_display_top u_dut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_write_i  (cmd_write_i),
		.cmd_addr_i   (cmd_addr_i),
		.cmd_data_i   (cmd_data_i),
		.cmd_credit_o (cmd_credit_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_addr_o   (rsp_addr_o),
		.rsp_data_o   (rsp_data_o),
		.rsp_credit_i (rsp_credit_i),
		.hs_o         (hs_o),
		.vs_o         (vs_o),
		.de_o         (de_o),
		.rgb_o        (rgb_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// colour rule, first match wins
	function automatic grid_display_pkg::rgb_t pixel_colour(input int x, input int y);
		int col;
		int row;
		col = (x - `FIELD_LO) / 32;
		row = (y - `FIELD_LO) / 32;
		if ((x < `FIELD_LO) || (x > `FIELD_X_HI) || (y < `FIELD_LO) || (y > `FIELD_Y_HI))
			return '0;
		if ((x == `FIELD_LO) || (x == `FIELD_X_HI) || (y == `FIELD_LO) || (y == `FIELD_Y_HI))
			return `COLOR_BORDER;
		if (((x % 32) == 0) || ((y % 32) == 0))
			return `COLOR_GRIDLINE;
		if (ref_cells[row * `GRID_COLS + col])
			return `COLOR_CELL;
		return '0;
	endfunction

	// credits left after this edge, counting the command on the bus now
	function automatic int cmd_avail();
		return cmd_credits - int'(cmd_valid_i) + int'(cmd_credit_o);
	endfunction

	always_comb
		exp_colour = pixel_colour(px, py);

	always_comb
	begin
		exp_rsp_addr = exp_addr_tbl[rsp_recv_cnt % 256];
		exp_rsp_data = exp_data_tbl[rsp_recv_cnt % 256];
	end

	////////////////////////////////////////
	// host channel bookkeeping
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cmd_credits    <= `CMD_DEPTH;
			cmd_sent_cnt   <= 0;
			cmd_credit_cnt <= 0;
			rsp_recv_cnt   <= 0;
			credit_ret_cnt <= 0;
		end
		else
		begin
			cmd_credits    <= cmd_avail();
			cmd_sent_cnt   <= cmd_sent_cnt + int'(cmd_valid_i);
			cmd_credit_cnt <= cmd_credit_cnt + int'(cmd_credit_o);
			rsp_recv_cnt   <= rsp_recv_cnt + int'(rsp_valid_o);
			credit_ret_cnt <= credit_ret_cnt + int'(rsp_credit_i);
		end
	end

	// return response credits after random gaps unless held back
	initial
	begin : credit_return
		int gap;
		gap = 0;
		wait (rst_n_i === 1'b1);
		forever
		begin
			@(posedge clk);
			if (!withhold && (gap == 0) &&
				((rsp_recv_cnt - credit_ret_cnt - int'(rsp_credit_i)) > 0))
			begin
				rsp_credit_i <= 1'b1;
				gap = gap_tbl[credit_ret_cnt % 64];
			end
			else
			begin
				rsp_credit_i <= 1'b0;
				if (gap > 0)
					gap--;
			end
		end
	end

	////////////////////////////////////////
	// pixel tracker
	////////////////////////////////////////

	assign hs_fall = hs_prev && !hs_o;
	assign hs_rise = !hs_prev && hs_o;
	assign vs_fall = vs_prev && !vs_o;
	assign vs_rise = !vs_prev && vs_o;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hs_prev     <= 1'b1;
			vs_prev     <= 1'b1;
			line_had_de <= 1'b0;
			hs_seen     <= 1'b0;
			px          <= 0;
			py          <= 0;
			hs_low_len  <= 0;
			vs_low_len  <= 0;
			hs_period   <= 0;
			pix_checked <= 0;
		end
		else
		begin
			hs_prev <= hs_o;
			vs_prev <= vs_o;
			// x restarts on every blank stretch
			px <= de_o ? px + 1 : 0;
			// y counts lines that carried data, zeroed during vsync
			if (!vs_o)
			begin
				py          <= 0;
				line_had_de <= 1'b0;
			end
			else if (hs_fall)
			begin
				if (line_had_de)
					py <= py + 1;
				line_had_de <= 1'b0;
			end
			else if (de_o)
				line_had_de <= 1'b1;
			hs_low_len <= hs_o ? 0 : hs_low_len + 1;
			vs_low_len <= vs_o ? 0 : vs_low_len + 1;
			if (hs_fall)
			begin
				hs_period <= 1;
				hs_seen   <= 1'b1;
			end
			else
				hs_period <= hs_period + 1;
			if (render_en && de_o)
				pix_checked <= pix_checked + 1;
		end
	end

	////////////////////////////////////////
	// checking assertions
	////////////////////////////////////////

	// outstanding commands stay within 0..CMD_DEPTH
	a_cmd_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		(cmd_credits >= 0) && (cmd_credits <= `CMD_DEPTH))
		else
		begin
			errors++;
			$display("[ERROR] %0t cmd_credits expected 0..%0d got %0d", $time, `CMD_DEPTH,
				$sampled(cmd_credits));
		end

	a_rsp_order: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_valid_o |-> ((rsp_recv_cnt < rd_sent_cnt) && (rsp_addr_o == exp_rsp_addr)))
		else
		begin
			errors++;
			$display("[ERROR] %0t rsp_addr_o expected %0d got %0d", $time,
				$sampled(exp_rsp_addr), $sampled(rsp_addr_o));
		end

	a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_valid_o |-> (rsp_data_o == exp_rsp_data))
		else
		begin
			errors++;
			$display("[ERROR] %0t rsp_data_o expected %0b got %0b", $time,
				$sampled(exp_rsp_data), $sampled(rsp_data_o));
		end

	// never more responses than credits handed out
	a_rsp_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_valid_o |-> ((rsp_recv_cnt - credit_ret_cnt) < `RSP_DEPTH))
		else
		begin
			errors++;
			$display("[ERROR] %0t rsp_valid_o unreturned credits expected <%0d got %0d",
				$time, `RSP_DEPTH, $sampled(rsp_recv_cnt - credit_ret_cnt));
		end

	a_render: assert property (@(posedge clk) disable iff (!rst_n_i)
		(render_en && de_o) |-> (rgb_o == exp_colour))
		else
		begin
			errors++;
			$display("[ERROR] %0t rgb_o expected %h got %h at x %0d y %0d", $time,
				$sampled(exp_colour), $sampled(rgb_o), $sampled(px), $sampled(py));
		end

	a_blank_black: assert property (@(posedge clk) disable iff (!rst_n_i)
		!de_o |-> (rgb_o == '0))
		else
		begin
			errors++;
			$display("[ERROR] %0t rgb_o expected 0 got %h", $time, $sampled(rgb_o));
		end

	a_hs_width: assert property (@(posedge clk) disable iff (!rst_n_i)
		hs_rise |-> (hs_low_len == `H_SYNC))
		else
		begin
			errors++;
			$display("[ERROR] %0t hs_o low cycles expected %0d got %0d", $time, `H_SYNC,
				$sampled(hs_low_len));
		end

	a_hs_period: assert property (@(posedge clk) disable iff (!rst_n_i)
		(hs_fall && hs_seen) |-> (hs_period == `H_TOTAL))
		else
		begin
			errors++;
			$display("[ERROR] %0t hs_o period expected %0d got %0d", $time, `H_TOTAL,
				$sampled(hs_period));
		end

	a_vs_width: assert property (@(posedge clk) disable iff (!rst_n_i)
		vs_rise |-> (vs_low_len == `V_SYNC * `H_TOTAL))
		else
		begin
			errors++;
			$display("[ERROR] %0t vs_o low cycles expected %0d got %0d", $time,
				`V_SYNC * `H_TOTAL, $sampled(vs_low_len));
		end

	////////////////////////////////////////
	// host tasks
	////////////////////////////////////////

	// one command per call, waits for a credit first
	task automatic send_cmd(input logic wr, input logic [7:0] addr, input logic data);
		@(posedge clk);
		while (cmd_avail() == 0)
		begin
			cmd_valid_i <= 1'b0;
			@(posedge clk);
		end
		cmd_valid_i <= 1'b1;
		cmd_write_i <= wr;
		cmd_addr_i  <= addr;
		cmd_data_i  <= data;
		if (wr)
		begin
			// cells past the grid keep no value
			if (addr < `GRID_CELLS)
				ref_cells[addr] = data;
		end
		else
		begin
			exp_addr_tbl[rd_sent_cnt % 256] = addr;
			exp_data_tbl[rd_sent_cnt % 256] = (addr < `GRID_CELLS) ? ref_cells[addr] : 1'b0;
			rd_sent_cnt++;
		end
	endtask

	task automatic idle_cmd();
		@(posedge clk);
		cmd_valid_i <= 1'b0;
	endtask

	// all commands credited, all reads answered and credited back
	task automatic wait_drained();
		@(posedge clk);
		while ((cmd_credits != `CMD_DEPTH) || cmd_valid_i || (rsp_recv_cnt != rd_sent_cnt) ||
			(credit_ret_cnt != rsp_recv_cnt) || rsp_credit_i)
			@(posedge clk);
	endtask

	task automatic wait_vsync_start();
		@(posedge clk);
		while (!vs_fall)
			@(posedge clk);
	endtask

	task automatic check_totals();
		a_credit_total: assert (cmd_credit_cnt == cmd_sent_cnt)
			else
			begin
				errors++;
				$display("[ERROR] %0t cmd_credit_o pulses expected %0d got %0d", $time,
					cmd_sent_cnt, cmd_credit_cnt);
			end
		a_rsp_total: assert (rsp_recv_cnt == rd_sent_cnt)
			else
			begin
				errors++;
				$display("[ERROR] %0t rsp_valid_o count expected %0d got %0d", $time,
					rd_sent_cnt, rsp_recv_cnt);
			end
		a_pix_total: assert (pix_checked == `H_ACTIVE * `V_ACTIVE)
			else
			begin
				errors++;
				$display("[ERROR] %0t de_o pixels expected %0d got %0d", $time,
					`H_ACTIVE * `V_ACTIVE, pix_checked);
			end
	endtask

	task automatic print_summary();
		$display("commands %0d credits %0d reads %0d responses %0d pixels %0d errors %0d",
			cmd_sent_cnt, cmd_credit_cnt, rd_sent_cnt, rsp_recv_cnt, pix_checked, errors);
	endtask

	////////////////////////////////////////
	// run limit
	////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
			print_summary();
			$display("sim failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial
	begin : stimulus
		int         i;
		logic       wr;
		logic [7:0] addr;
		seed         = 33;
		errors       = 0;
		cycle_cnt    = 0;
		rd_sent_cnt  = 0;
		rst_n_i      = 1'b0;
		cmd_valid_i  = 1'b0;
		cmd_write_i  = 1'b0;
		cmd_addr_i   = '0;
		cmd_data_i   = 1'b0;
		rsp_credit_i = 1'b0;
		withhold     = 1'b0;
		render_en    = 1'b0;
		for (i = 0; i < 256; i++)
		begin
			ref_cells[i]    = 1'b0;
			exp_addr_tbl[i] = '0;
			exp_data_tbl[i] = 1'b0;
		end
		// credit return gaps, one per returned credit
		for (i = 0; i < 64; i++)
			gap_tbl[i] = $unsigned($random(seed)) % 4;
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;

		// fill every cell
		for (i = 0; i < `GRID_CELLS; i++)
			send_cmd(1'b1, 8'(i), 1'($random(seed)));

		// mixed reads and writes, order matters
		for (i = 0; i < 40; i++)
		begin
			wr   = 1'($random(seed));
			addr = 8'($unsigned($random(seed)) % `GRID_CELLS);
			send_cmd(wr, addr, 1'($random(seed)));
		end

		// past the last cell
		send_cmd(1'b1, 8'd240, 1'b1);
		send_cmd(1'b0, 8'd240, 1'b0);
		idle_cmd();
		wait_drained();

		// hold response credits, reads pile up
		withhold <= 1'b1;
		for (i = 0; i < 8; i++)
			send_cmd(1'b0, 8'($unsigned($random(seed)) % `GRID_CELLS), 1'b0);
		idle_cmd();
		repeat (64) @(posedge clk);
		withhold <= 1'b0;
		wait_drained();

		// check one full frame against the final cell contents
		wait_vsync_start();
		render_en <= 1'b1;
		wait_vsync_start();
		render_en <= 1'b0;
		repeat (4) @(posedge clk);

		check_totals();
		print_summary();
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- grid_display.f
+incdir+.
grid_display_pkg.sv
credit_fifo.sv
vga_timing.sv
grid_vram.sv
grid_cmd_port.sv
grid_display_top.sv
tb_grid_display.sv
